// File: verilog/fifo_demo_pkg.sv
`default_nettype none

package fifo_demo_pkg;

    //------------------------------------------------------------------------
    // Widths and sizes

    localparam int data_width  = 4;
    localparam int fifo_depth  = 8;
    localparam int level_width = 4;
    localparam int index_width = 4;
    localparam int n_digits    = 4;

    // Clocks per digit slot, kept short for simulation
    localparam int scan_div    = 4;

    localparam logic [level_width - 1:0] full_level = level_width'(fifo_depth);

    // Fixed upstream sequence
    localparam logic [data_width - 1:0] source_table [2 ** index_width] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    //------------------------------------------------------------------------
    // Segment codes, abcdefgh with a on top and the dot at bit 0

    localparam logic [7:0] sign_valid   = 8'b1000_0000;
    localparam logic [7:0] sign_ready   = 8'b0000_0010;
    localparam logic [7:0] sign_nothing = 8'b0000_0000;

    function automatic logic [7:0] hex_segments(input logic [data_width - 1:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // Digit slot, encoding equals the digit bit it lights
    typedef enum logic [1:0] {
        pos_down_data = 2'd0,
        pos_down_hs   = 2'd1,
        pos_up_hs     = 2'd2,
        pos_up_data   = 2'd3
    } scan_pos_t;

    typedef struct packed {
        logic                     up_ready;
        logic                     down_valid;
        logic [level_width - 1:0] level;
        logic [data_width - 1:0]  down_data;
    } fifo_status_t;

endpackage

`default_nettype wire

// File: verilog/sequence_source.sv
`timescale 1ns/1ps
`default_nettype none

module sequence_source (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 push,
    output logic [fifo_demo_pkg::data_width - 1:0] up_data
);

    //------------------------------------------------------------------------
    // Table index

    // Wraps after the last entry
    logic [fifo_demo_pkg::index_width - 1:0] index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end
        else if (push) begin
            index <= index + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Offered value

    // Holds steady while the index is unchanged
    assign up_data = fifo_demo_pkg::source_table[index];

endmodule

`default_nettype wire

// File: verilog/valid_ready_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module valid_ready_fifo (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Upstream side
    input  logic                                  up_valid,
    output logic                                  up_ready,
    input  logic [fifo_demo_pkg::data_width - 1:0]  up_data,

    // Downstream side
    output logic                                  down_valid,
    input  logic                                  down_ready,
    output logic [fifo_demo_pkg::data_width - 1:0] down_data,

    output logic [fifo_demo_pkg::level_width - 1:0] level
);

    typedef logic [$clog2(fifo_demo_pkg::fifo_depth) - 1:0] ptr_t;

    logic [fifo_demo_pkg::data_width - 1:0] mem [fifo_demo_pkg::fifo_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic push;
    logic pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(fifo_demo_pkg::fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //------------------------------------------------------------------------
    // Handshake decode

    assign up_ready   = (level != fifo_demo_pkg::full_level);
    assign down_valid = (level != '0);

    // Transfers happen only when both sides agree
    assign push = up_valid & up_ready;
    assign pop  = down_valid & down_ready;

    // Oldest entry
    assign down_data = mem[rd_ptr];

    //------------------------------------------------------------------------
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= up_data;
        end
    end

    //------------------------------------------------------------------------
    // Pointers and level

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // Push with pop leaves the level alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end
        else begin
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/seven_segment_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module seven_segment_scanner (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic [fifo_demo_pkg::data_width - 1:0]  up_data,
    input  logic                                  up_valid,
    input  logic                                  up_ready,

    input  logic [fifo_demo_pkg::data_width - 1:0]  down_data,
    input  logic                                  down_valid,
    input  logic                                  down_ready,

    output logic [7:0]                            abcdefgh,
    output logic [fifo_demo_pkg::n_digits - 1:0]    digit
);

    logic [$clog2(fifo_demo_pkg::scan_div) - 1:0] div_cnt;
    logic                                         slot_end;
    fifo_demo_pkg::scan_pos_t                     pos;
    fifo_demo_pkg::scan_pos_t                     pos_next;

    // Valid lights the top bar, ready the middle one
    function automatic logic [7:0] hs_sign(input logic valid, input logic ready);
        logic [7:0] seg;
        seg = fifo_demo_pkg::sign_nothing;
        if (valid) begin
            seg = seg | fifo_demo_pkg::sign_valid;
        end
        if (ready) begin
            seg = seg | fifo_demo_pkg::sign_ready;
        end
        return seg;
    endfunction

    //------------------------------------------------------------------------
    // Slot timing

    assign slot_end = (div_cnt == (fifo_demo_pkg::scan_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end
        else if (slot_end) begin
            div_cnt <= '0;
        end
        else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Scan order follows the digit bits
    always_comb begin
        case (pos)
            fifo_demo_pkg::pos_down_data: pos_next = fifo_demo_pkg::pos_down_hs;
            fifo_demo_pkg::pos_down_hs:   pos_next = fifo_demo_pkg::pos_up_hs;
            fifo_demo_pkg::pos_up_hs:     pos_next = fifo_demo_pkg::pos_up_data;
            default:                      pos_next = fifo_demo_pkg::pos_down_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= fifo_demo_pkg::pos_down_data;
        end
        else if (slot_end) begin
            pos <= pos_next;
        end
    end

    //------------------------------------------------------------------------
    // Digit select and segments

    always_comb begin
        digit      = '0;
        digit[pos] = 1'b1;
    end

    always_comb begin
        case (pos)
            fifo_demo_pkg::pos_up_data: begin
                abcdefgh = fifo_demo_pkg::hex_segments(up_data);
            end
            fifo_demo_pkg::pos_up_hs: begin
                abcdefgh = hs_sign(up_valid, up_ready);
            end
            fifo_demo_pkg::pos_down_hs: begin
                abcdefgh = hs_sign(down_valid, down_ready);
            end
            default: begin
                // Blank while nothing is offered downstream
                abcdefgh = down_valid ? fifo_demo_pkg::hex_segments(down_data)
                                      : fifo_demo_pkg::sign_nothing;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/fifo_demo_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_demo_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [1:0]                         key,
    output fifo_demo_pkg::fifo_status_t        status,
    output logic [7:0]                         abcdefgh,
    output logic [fifo_demo_pkg::n_digits - 1:0] digit
);

    //------------------------------------------------------------------------
    // Handshake nets

    logic                                   up_valid;
    logic                                   up_ready;
    logic [fifo_demo_pkg::data_width - 1:0]  up_data;
    logic                                   down_valid;
    logic                                   down_ready;
    logic [fifo_demo_pkg::data_width - 1:0]  down_data;
    logic [fifo_demo_pkg::level_width - 1:0] level;

    // key[1] offers upstream, key[0] accepts downstream
    assign up_valid   = key[1];
    assign down_ready = key[0];

    //------------------------------------------------------------------------
    // Blocks

    sequence_source source0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (up_valid & up_ready),
        .up_data (up_data)
    );

    valid_ready_fifo fifo0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_valid   (up_valid),
        .up_ready   (up_ready),
        .up_data    (up_data),
        .down_valid (down_valid),
        .down_ready (down_ready),
        .down_data  (down_data),
        .level      (level)
    );

    seven_segment_scanner scanner0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_data    (up_data),
        .up_valid   (up_valid),
        .up_ready   (up_ready),
        .down_data  (down_data),
        .down_valid (down_valid),
        .down_ready (down_ready),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

    // Status word for the LEDs
    always_comb begin
        status.up_ready   = up_ready;
        status.down_valid = down_valid;
        status.level      = level;
        status.down_data  = down_data;
    end

endmodule

`default_nettype wire

// File: test/fifo_demo_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_demo_asserts (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   up_valid,
    input logic                                   up_ready,
    input logic                                   down_valid,
    input logic [fifo_demo_pkg::level_width - 1:0] level,
    input logic [fifo_demo_pkg::n_digits - 1:0]    digit
);

    //------------------------------------------------------------------------
    // FIFO occupancy

    // A full FIFO takes no push
    no_push_at_full: assert property (@(posedge clk) disable iff (!rst_n)
        (level == fifo_demo_pkg::full_level) |-> !(up_valid && up_ready))
        else $error("push accepted while the FIFO is full");

    level_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        level <= fifo_demo_pkg::full_level)
        else $error("level is above the FIFO depth");

    valid_from_level: assert property (@(posedge clk) disable iff (!rst_n)
        down_valid == (level != '0))
        else $error("down_valid does not follow the level");

    //------------------------------------------------------------------------
    // Display scan

    digit_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit))
        else $error("digit select is not one-hot");

endmodule

// Top level holds both the FIFO and the scanner nets
bind fifo_demo_top fifo_demo_asserts asserts0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .up_valid   (up_valid),
    .up_ready   (up_ready),
    .down_valid (down_valid),
    .level      (level),
    .digit      (digit)
);

`default_nettype wire

// File: test/tb_fifo_demo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_demo;

    localparam int half_period   = 4;
    localparam int reset_cycles  = 4;
    localparam int random_cycles = 200;
    localparam int table_size    = 16;
    localparam int depth         = fifo_demo_pkg::fifo_depth;
    localparam int scan_cycles   = fifo_demo_pkg::scan_div * fifo_demo_pkg::n_digits;
    // Cycles of all tests in run order plus a margin
    localparam int test_cycles   = reset_cycles + 10 + 23 + random_cycles + depth
                                   + 5 * scan_cycles;
    localparam int margin_cycles = 200;

    // Standard hex glyphs in abcdefgh order with the dot off
    localparam logic [7:0] glyphs [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };
    localparam logic [7:0] seg_a = 8'h80;
    localparam logic [7:0] seg_g = 8'h02;

    logic                                   clk;
    logic                                   rst_n;
    logic [1:0]                             key;
    fifo_demo_pkg::fifo_status_t            status;
    logic [7:0]                             abcdefgh;
    logic [fifo_demo_pkg::n_digits - 1:0]    digit;

    // Reference model
    logic [fifo_demo_pkg::data_width - 1:0] model_q [$];
    int                                     src_idx;
    int                                     cycle_count;
    int                                     total_pushes;
    int                                     both_count;
    logic [3:0]                             slots_seen;
    int                                     checks;
    int                                     errors;
    int                                     seed_ret;

    fifo_demo_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .status   (status),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always begin
        #half_period clk = ~clk;
    end

    task automatic check_value(input string test, input string field,
                               input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[FAIL] %s: %s expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic check_status(input string test);
        int size;
        size = model_q.size();
        check_value(test, "level", size, int'(status.level));
        check_value(test, "up_ready", (size < depth) ? 1 : 0, int'(status.up_ready));
        check_value(test, "down_valid", (size > 0) ? 1 : 0, int'(status.down_valid));
        if (size > 0) begin
            check_value(test, "down_data", int'(model_q[0]), int'(status.down_data));
        end
    endtask

    // Runs one clock with keys k from falling edge to falling edge
    task automatic step(input logic [1:0] k);
        logic push;
        logic pop;
        key  = k;
        push = k[1] && (model_q.size() < depth);
        pop  = k[0] && (model_q.size() > 0);
        if (push && pop) begin
            both_count++;
        end
        @(posedge clk);
        cycle_count++;
        if (pop) begin
            model_q.delete(0);
        end
        if (push) begin
            model_q.push_back(fifo_demo_pkg::source_table[src_idx]);
            src_idx = (src_idx + 1) % table_size;
            total_pushes++;
        end
        @(negedge clk);
    endtask

    task automatic check_display(input string test);
        logic [7:0]                           expected;
        logic [fifo_demo_pkg::n_digits - 1:0] expected_digit;
        int                                   size;
        size = model_q.size();
        // Slot advances every scan_div clocks counted from reset release
        expected_digit = 4'b0001 << ((cycle_count / fifo_demo_pkg::scan_div)
                                     % fifo_demo_pkg::n_digits);
        check_value(test, "digit", int'(expected_digit), int'(digit));
        case (digit)
            4'b0001: expected = (size > 0) ? glyphs[model_q[0]] : 8'h00;
            4'b0010: expected = ((size > 0) ? seg_a : 8'h00) | (key[0] ? seg_g : 8'h00);
            4'b0100: expected = (key[1] ? seg_a : 8'h00) | ((size < depth) ? seg_g : 8'h00);
            4'b1000: expected = glyphs[fifo_demo_pkg::source_table[src_idx]];
            default: begin
                errors++;
                $display("%s: digit select %b is not one-hot", test, digit);
                return;
            end
        endcase
        slots_seen = slots_seen | digit;
        check_value(test, $sformatf("segments on digit %b", digit), expected, abcdefgh);
    endtask

    task automatic display_phase(input string test, input logic [1:0] k);
        int i;
        slots_seen = '0;
        for (i = 0; i < scan_cycles; i++) begin
            step(k);
            check_status(test);
            check_display(test);
        end
        if (slots_seen != 4'b1111) begin
            errors++;
            $display("%s: not every digit slot was scanned, seen %b", test, slots_seen);
        end
    endtask

    //------------------------------------------------------------------------
    // Directed tests

    task automatic test_reset();
        rst_n = 1'b0;
        key   = 2'b00;
        model_q.delete();
        src_idx     = 0;
        cycle_count = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset", "up_ready", 1, int'(status.up_ready));
        check_value("reset", "down_valid", 0, int'(status.down_valid));
        check_value("reset", "level", 0, int'(status.level));
        check_value("reset", "digit", 1, int'(digit));
    endtask

    task automatic test_order();
        int i;
        for (i = 0; i < 5; i++) begin
            step(2'b10);
            check_value("order", "level", i + 1, int'(status.level));
        end
        for (i = 0; i < 5; i++) begin
            check_value("order", "down_data", int'(fifo_demo_pkg::source_table[i]),
                        int'(status.down_data));
            step(2'b01);
            check_value("order", "level", 4 - i, int'(status.level));
        end
    endtask

    task automatic test_backpressure();
        int start;
        int i;
        start = src_idx;
        for (i = 0; i < 12; i++) begin
            step(2'b10);
            check_status("backpressure");
        end
        check_value("backpressure", "level", depth, int'(status.level));
        check_value("backpressure", "up_ready", 0, int'(status.up_ready));
        step(2'b00);
        for (i = 0; i < depth; i++) begin
            check_value("backpressure", "down_data",
                        int'(fifo_demo_pkg::source_table[(start + i) % table_size]),
                        int'(status.down_data));
            step(2'b01);
        end
        check_value("backpressure", "level", 0, int'(status.level));
        // Ignored presses must not have moved the source on
        step(2'b10);
        check_value("backpressure", "next down_data",
                    int'(fifo_demo_pkg::source_table[(start + depth) % table_size]),
                    int'(status.down_data));
        step(2'b01);
        check_status("backpressure");
    endtask

    task automatic test_random();
        logic [1:0] k;
        int         i;
        both_count = 0;
        for (i = 0; i < random_cycles; i++) begin
            k = 2'($urandom_range(0, 3));
            step(k);
            check_status("random");
        end
        if (both_count == 0) begin
            errors++;
            $display("random: no cycle had a push and a pop together");
        end
        if (total_pushes <= table_size) begin
            errors++;
            $display("random: the source table never wrapped");
        end
    endtask

    task automatic test_display();
        while (model_q.size() > 0) begin
            step(2'b01);
        end
        display_phase("display empty", 2'b00);
        display_phase("display fill", 2'b10);
        display_phase("display full", 2'b11);
        display_phase("display drain", 2'b01);
        display_phase("display idle", 2'b00);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        key          = 2'b00;
        checks       = 0;
        errors       = 0;
        cycle_count  = 0;
        total_pushes = 0;
        both_count   = 0;
        slots_seen   = '0;
        seed_ret     = $urandom(95492);
        test_reset();
        test_order();
        test_backpressure();
        test_random();
        test_display();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((test_cycles + margin_cycles) * 2 * half_period);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/fifo_demo_pkg.sv
verilog/sequence_source.sv
verilog/valid_ready_fifo.sv
verilog/seven_segment_scanner.sv
verilog/fifo_demo_top.sv
test/fifo_demo_asserts.sv
test/tb_fifo_demo.sv

// File: Makefile
SOURCES := $(shell cat all.f)

.PHONY: run clean

obj_dir/Vtb_fifo_demo: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_fifo_demo -Mdir obj_dir -o Vtb_fifo_demo

run: obj_dir/Vtb_fifo_demo
	./obj_dir/Vtb_fifo_demo > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
